// File: mat_add.f
hdl/mat_bus_pkg.sv
hdl/mat_add_pkg.sv
hdl/mat_add_engine.sv
hdl/mat_add_regs.sv
hdl/mat_add_top.sv
tests/mat_add_properties.sv
tests/mat_add_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mat_add testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    -f mat_add.f \
    --top-module mat_add_tb \
    -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vmat_add_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q "** PASS **" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// File: tests/mat_add_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mat_add_tb;

    localparam int unsigned lanes      = 4;
    localparam int          max_cycles = 2000;   // about ten times the test length

    logic                  clk;
    logic                  reset;
    mat_bus_pkg::avl_req_t avl_req;
    mat_bus_pkg::avl_rsp_t avl_rsp;

    // model copies of the operand banks
    mat_add_pkg::lane_t a_ref [lanes];
    mat_add_pkg::lane_t b_ref [lanes];

    logic [31:0] lcg_state;
    int          errors;
    int          cycles;

    mat_add_top #(
        .lane_count (lanes)
    ) mat_add_top_inst (
        .clk     (clk),
        .reset   (reset),
        .avl_req (avl_req),
        .avl_rsp (avl_rsp)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic rand_word(output mat_add_pkg::lane_t w);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        w  = {hi, lo};
    endtask

    task automatic check_lane(input string name, input mat_add_pkg::lane_t expected,
                              input mat_add_pkg::lane_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic avl_write(input mat_bus_pkg::addr_t address, input mat_bus_pkg::data_t data,
                             input mat_bus_pkg::be_t be);
        @(posedge clk);
        avl_req.address    <= address;
        avl_req.writedata  <= data;
        avl_req.byteenable <= be;
        avl_req.write      <= 1'b1;
        avl_req.read       <= 1'b0;
        @(negedge clk);
        while (avl_rsp.waitrequest)   // request held while stalled
            @(negedge clk);
        @(posedge clk);
        avl_req.write <= 1'b0;
    endtask

    task automatic avl_read(input mat_bus_pkg::addr_t address, output mat_bus_pkg::data_t data);
        @(posedge clk);
        avl_req.address <= address;
        avl_req.read    <= 1'b1;
        avl_req.write   <= 1'b0;
        @(negedge clk);
        while (avl_rsp.waitrequest)
            @(negedge clk);
        data = avl_rsp.readdata;   // zero latency, stable mid cycle
        @(posedge clk);
        avl_req.read <= 1'b0;
    endtask

    // bank 0 is a, bank 1 is b
    task automatic load_word(input int bank, input int idx, input mat_bus_pkg::data_t data,
                             input mat_bus_pkg::be_t be);
        for (int k = 0; k < 8; k++)
        begin
            if (be[k] && bank == 0)
                a_ref[idx][8*k +: 8] = data[8*k +: 8];
            if (be[k] && bank == 1)
                b_ref[idx][8*k +: 8] = data[8*k +: 8];
        end
        avl_write(mat_bus_pkg::addr_t'(bank * lanes + idx), data, be);
    endtask

    task automatic start_command();
        avl_write(mat_bus_pkg::addr_t'(2 * lanes), '0, 8'hFF);
    endtask

    task automatic run_command();
        start_command();
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            check_flag("waitrequest", 1'b1, avl_rsp.waitrequest);
        end
        @(negedge clk);
        check_flag("waitrequest", 1'b0, avl_rsp.waitrequest);
    endtask

    task automatic check_sums();
        mat_add_pkg::lane_t rd;
        for (int i = 0; i < lanes; i++)
        begin
            avl_read(mat_bus_pkg::addr_t'(i), rd);
            check_lane($sformatf("c[%0d]", i), a_ref[i] + b_ref[i], rd);   // wraps at 64 bits
        end
    endtask

    task automatic reset_state();
        mat_add_pkg::lane_t rd;
        @(negedge clk);
        check_flag("waitrequest", 1'b0, avl_rsp.waitrequest);
        for (int i = 0; i < lanes; i++)
        begin
            avl_read(mat_bus_pkg::addr_t'(i), rd);
            check_lane($sformatf("c[%0d]", i), '0, rd);
        end
    endtask

    task automatic full_word_add();
        mat_add_pkg::lane_t w;
        for (int i = 0; i < lanes; i++)
        begin
            rand_word(w);
            load_word(0, i, w, 8'hFF);
            rand_word(w);
            load_word(1, i, w, 8'hFF);
        end
        run_command();
        check_sums();
    endtask

    // random data in the disabled half must not land
    task automatic half_word_add(input mat_bus_pkg::be_t be);
        mat_add_pkg::lane_t w;
        for (int i = 0; i < lanes; i++)
        begin
            rand_word(w);
            load_word(0, i, w, be);
            rand_word(w);
            load_word(1, i, w, be);
        end
        run_command();
        check_sums();
    endtask

    task automatic carry_add();
        load_word(0, 0, 64'h0000_0000_ffff_ffff, 8'hFF);   // low half overflow
        load_word(1, 0, 64'h0000_0000_0000_0001, 8'hFF);
        load_word(0, 1, 64'hffff_ffff_ffff_ffff, 8'hFF);   // wraps past 2^64
        load_word(1, 1, 64'h0000_0000_0000_0002, 8'hFF);
        load_word(0, 2, 64'h8000_0000_0000_0000, 8'hFF);
        load_word(1, 2, 64'h8000_0000_0000_0000, 8'hFF);
        load_word(0, 3, 64'h0000_0001_8000_0000, 8'hFF);
        load_word(1, 3, 64'h0000_0002_8000_0000, 8'hFF);
        run_command();
        check_sums();
    endtask

    task automatic stalled_transfer();
        mat_add_pkg::lane_t w;
        mat_add_pkg::lane_t rd;
        mat_add_pkg::lane_t old_sum;
        for (int i = 0; i < lanes; i++)
        begin
            rand_word(w);
            load_word(0, i, w, 8'hFF);
        end
        start_command();
        avl_read('0, rd);   // lands in the busy window
        check_lane("stalled read c[0]", a_ref[0] + b_ref[0], rd);
        start_command();
        rand_word(w);
        old_sum = a_ref[1] + b_ref[1];
        avl_write(mat_bus_pkg::addr_t'(1), w, 8'hFF);
        avl_read(mat_bus_pkg::addr_t'(1), rd);
        check_lane("c[1] before stalled write", old_sum, rd);
        a_ref[1] = w;
        run_command();
        check_sums();
    endtask

    task automatic unmapped_read();
        mat_add_pkg::lane_t rd;
        for (int addr = lanes; addr < 16; addr++)
        begin
            avl_read(mat_bus_pkg::addr_t'(addr), rd);
            check_lane($sformatf("readdata at %0d", addr), '0, rd);
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        avl_req   = '0;
        errors    = 0;
        cycles    = 0;
        lcg_state = 32'd41;
        for (int i = 0; i < lanes; i++)
        begin
            a_ref[i] = '0;
            b_ref[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        reset_state();
        full_word_add();
        half_word_add(8'h0F);
        half_word_add(8'hF0);
        carry_add();
        stalled_transfer();
        unmapped_read();

        // bound assertion failures count as errors too
        errors += mat_add_top_inst.mat_add_regs_inst.mat_add_properties_inst.failures;
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/mat_add_properties.sv
`timescale 1ns/10ps
`default_nettype none

module mat_add_properties
(
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic done,
    input wire logic waitrequest
);

    int unsigned failures = 0;

    // engine latency is fixed at two cycles
    done_after_start: assert property (@(posedge clk) disable iff (reset)
        start |-> ##2 done)
    else
    begin
        failures++;
        $error("done did not follow start by two cycles");
    end

    done_has_start: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(start, 2))
    else
    begin
        failures++;
        $error("done without a start two cycles earlier");
    end

    start_one_cycle: assert property (@(posedge clk) disable iff (reset)
        start |=> !start)
    else
    begin
        failures++;
        $error("start held for more than one cycle");
    end

    // launch, wait_done twice, store
    wait_four_cycles: assert property (@(posedge clk) disable iff (reset)
        $rose(waitrequest) |-> waitrequest ##1 waitrequest ##1 waitrequest
            ##1 waitrequest ##1 !waitrequest)
    else
    begin
        failures++;
        $error("waitrequest not high for exactly four cycles");
    end

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !waitrequest)
    else
    begin
        failures++;
        $error("waitrequest high right after reset");
    end

endmodule

bind mat_add_regs mat_add_properties mat_add_properties_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .done        (done),
    .waitrequest (waitrequest)
);

`default_nettype wire

// File: hdl/mat_add_top.sv
`timescale 1ns/10ps
`default_nettype none

// accelerator top, the avalon slave port goes straight to the register block
module mat_add_top
#(
    parameter int unsigned lane_count = 4   // 1 to 7, so the command word fits the address
)
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire mat_bus_pkg::avl_req_t avl_req,
    output mat_bus_pkg::avl_rsp_t      avl_rsp
);

    mat_add_regs #(
        .lane_count (lane_count)
    ) mat_add_regs_inst (
        .clk     (clk),
        .reset   (reset),
        .avl_req (avl_req),
        .avl_rsp (avl_rsp)
    );

endmodule

`default_nettype wire

// File: hdl/mat_add_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mat_add_regs
#(
    parameter int unsigned lane_count = 4
)
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire mat_bus_pkg::avl_req_t avl_req,
    output mat_bus_pkg::avl_rsp_t      avl_rsp
);

    localparam mat_bus_pkg::addr_t b_base   = mat_bus_pkg::bank_b_base(lane_count);
    localparam mat_bus_pkg::addr_t cmd_word = mat_bus_pkg::cmd_addr(lane_count);

    mat_add_pkg::ctrl_state_t state;

    mat_add_pkg::lane_t [lane_count-1:0] a_bank;
    mat_add_pkg::lane_t [lane_count-1:0] b_bank;
    mat_add_pkg::lane_t [lane_count-1:0] c_bank;
    mat_add_pkg::lane_t [lane_count-1:0] sum;

    mat_bus_pkg::data_t rd_data;
    logic               waitrequest;
    logic               wr_ok;
    logic               start;
    logic               done;

    assign waitrequest = (state != mat_add_pkg::idle);   // stalls everything during a command
    assign wr_ok       = avl_req.write && !waitrequest;
    assign start       = (state == mat_add_pkg::launch);

    mat_add_engine #(
        .lane_count (lane_count)
    ) mat_add_engine_inst (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .opa   (a_bank),   // banks cannot change while waitrequest is up
        .opb   (b_bank),
        .sum   (sum),
        .done  (done)
    );

    // operand banks, written a byte lane at a time
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            a_bank <= '0;
            b_bank <= '0;
        end
        else if (wr_ok)
        begin
            for (int i = 0; i < lane_count; i++)
            begin
                for (int k = 0; k < mat_bus_pkg::be_width; k++)
                begin
                    if (avl_req.byteenable[k])
                    begin
                        if (avl_req.address == mat_bus_pkg::addr_t'(i))
                            a_bank[i][8*k +: 8] <= avl_req.writedata[8*k +: 8];
                        if (avl_req.address == b_base + mat_bus_pkg::addr_t'(i))
                            b_bank[i][8*k +: 8] <= avl_req.writedata[8*k +: 8];
                    end
                end
            end
        end
    end

    // command sequencer
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= mat_add_pkg::idle;
            c_bank <= '0;
        end
        else
        begin
            case (state)
                mat_add_pkg::idle:
                begin
                    if (wr_ok && avl_req.address == cmd_word)
                        state <= mat_add_pkg::launch;
                end
                mat_add_pkg::launch:
                    state <= mat_add_pkg::wait_done;
                mat_add_pkg::wait_done:
                begin
                    if (done)   // two cycles after launch
                        state <= mat_add_pkg::store;
                end
                mat_add_pkg::store:
                begin
                    c_bank <= sum;   // engine holds sum until the next start
                    state  <= mat_add_pkg::idle;
                end
                default:
                    state <= mat_add_pkg::idle;
            endcase
        end
    end

    // results only, everything outside bank c reads as zero
    always_comb
    begin
        rd_data = '0;
        if (avl_req.read)
        begin
            for (int i = 0; i < lane_count; i++)
            begin
                if (avl_req.address == mat_bus_pkg::addr_t'(i))
                    rd_data = c_bank[i];
            end
        end
    end

    assign avl_rsp.readdata    = rd_data;
    assign avl_rsp.waitrequest = waitrequest;

endmodule

`default_nettype wire

// File: hdl/mat_add_engine.sv
`timescale 1ns/10ps
`default_nettype none

module mat_add_engine
#(
    parameter int unsigned lane_count = 4
)
(
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  start,
    input  wire mat_add_pkg::lane_t [lane_count-1:0]   opa,
    input  wire mat_add_pkg::lane_t [lane_count-1:0]   opb,
    output mat_add_pkg::lane_t [lane_count-1:0]        sum,
    output logic                                       done
);

    localparam int hw = mat_add_pkg::half_width;

    // what stage one hands to stage two, per lane
    typedef struct packed {
        mat_add_pkg::half_t a_hi;
        mat_add_pkg::half_t b_hi;
        mat_add_pkg::half_t lo;
        logic               carry;
    } stage1_t;

    stage1_t [lane_count-1:0] s1;
    mat_add_pkg::eng_status_t valid;

    // stage one, low halves plus carry out
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            for (int i = 0; i < lane_count; i++)
            begin
                {s1[i].carry, s1[i].lo} <= {1'b0, opa[i][hw-1:0]} + {1'b0, opb[i][hw-1:0]};
                s1[i].a_hi <= opa[i][2*hw-1:hw];
                s1[i].b_hi <= opb[i][2*hw-1:hw];
            end
        end
    end

    // stage two, high halves take the carry, top carry dropped (mod 2^64)
    always_ff @(posedge clk)
    begin
        if (valid.stage1)
        begin
            for (int i = 0; i < lane_count; i++)
                sum[i] <= {s1[i].a_hi + s1[i].b_hi + s1[i].carry, s1[i].lo};
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid <= '0;
        else
        begin
            valid.stage1 <= start;
            valid.stage2 <= valid.stage1;   // one done per start
        end
    end

    assign done = valid.stage2;

endmodule

`default_nettype wire

// File: hdl/mat_add_pkg.sv
`default_nettype none

// lane and controller types of the vector adder
package mat_add_pkg;

    localparam int lane_width = 64;
    localparam int half_width = lane_width / 2;   // carry split point

    typedef logic [lane_width-1:0] lane_t;
    typedef logic [half_width-1:0] half_t;

    // valid bits travelling down the adder pipeline
    typedef struct packed {
        logic stage1;
        logic stage2;
    } eng_status_t;

    typedef enum logic [1:0] {
        idle,
        launch,      // start pulse to the engine
        wait_done,
        store        // sums go to bank c
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/mat_bus_pkg.sv
`default_nettype none

// avalon slave port of the accelerator, word addressed
package mat_bus_pkg;

    localparam int addr_width = 4;
    localparam int data_width = 64;
    localparam int be_width   = data_width / 8;   // one enable per byte lane

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [be_width-1:0]   be_t;

    typedef struct packed {
        addr_t address;
        data_t writedata;
        be_t   byteenable;
        logic  write;
        logic  read;
    } avl_req_t;

    typedef struct packed {
        data_t readdata;
        logic  waitrequest;   // high while a command runs
    } avl_rsp_t;

    // address map, a at 0, b right after it, then the command word
    function automatic addr_t bank_b_base(input int unsigned lanes);
        return addr_t'(lanes);
    endfunction

    function automatic addr_t cmd_addr(input int unsigned lanes);
        return addr_t'(2 * lanes);
    endfunction

endpackage

`default_nettype wire
